/* files.f */
+incdir+src
src/cpuPkg.sv
src/controlSequencer.sv
src/instrDecode.sv
src/registerFile.sv
src/aluExecute.sv
src/busResult.sv
src/cpuCore.sv
testbench/clockGen.sv
testbench/cpuCoreTb.sv

/* Makefile */
RTL := src/cpuPkg.sv src/controlSequencer.sv src/instrDecode.sv src/registerFile.sv \
	src/aluExecute.sv src/busResult.sv src/cpuCore.sv

.PHONY: all lint clean

all: obj_dir/cpuCoreTb
	./obj_dir/cpuCoreTb | tee sim.log
	grep -q "^No errors$$" sim.log

obj_dir/cpuCoreTb: files.f $(RTL) src/cpu_settings.svh testbench/clockGen.sv testbench/cpuCoreTb.sv
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cpuCoreTb -o cpuCoreTb

lint:
	verilator --lint-only -Wall +incdir+src $(RTL) --top-module cpuCore

clean:
	rm -rf obj_dir sim.log

/* testbench/cpuCoreTb.sv */
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpuCoreTb;

        localparam int MemAddrBits = $clog2(`CPU_MEM_WORDS);
        localparam int NumInstr = 26;
        localparam int ResetCycles = 5;
        localparam int WatchdogCycles = (NumInstr * 9 + ResetCycles) * 2;

        logic Clock;
        logic arstN;
        logic start;
        logic memRead;
        logic memWrite;
        logic done;
        cpuPkg::wordT memAddr;
        cpuPkg::wordT memWriteData;
        cpuPkg::wordT memReadData;

        cpuPkg::wordT mem [`CPU_MEM_WORDS];
        cpuPkg::wordT refRegs [`CPU_NUM_REGS];
        cpuPkg::wordT pcModel;
        cpuPkg::wordT lastWrAddr;
        cpuPkg::wordT lastWrData;
        integer seed;
        int errorCount;
        int testCount;
        int testStartErrors;
        string currentTest;

        clockGen u_clock (
                .Clock(Clock),
                .arstN(arstN)
        );

        cpuCore u_dut (
                .Clock(Clock),
                .arstN(arstN),
                .start(start),
                .memReadData(memReadData),
                .memAddr(memAddr),
                .memWriteData(memWriteData),
                .memRead(memRead),
                .memWrite(memWrite),
                .done(done)
        );

        // reads are answered combinationally from the word addressed memory.
        assign memReadData = mem[memAddr[MemAddrBits-1:0]];

        // ====================================================================
        // instruction assembly and reference model
        // ====================================================================

        function automatic cpuPkg::wordT memInstr(cpuPkg::opcodeT op, cpuPkg::regIdxT ra,
                        cpuPkg::regIdxT rb, int c);
                logic [`CPU_IMM_WIDTH-1:0] cField;
                cField = c[`CPU_IMM_WIDTH-1:0];
                return {op, ra, rb, cField};
        endfunction

        function automatic cpuPkg::wordT aluInstr(cpuPkg::opcodeT op, cpuPkg::regIdxT ra,
                        cpuPkg::regIdxT rb, cpuPkg::regIdxT rc);
                return {op, ra, rb, rc, 15'b0};
        endfunction

        // Rb of zero reads as the value zero; Rc always reads the register.
        task automatic refExecute(input cpuPkg::wordT instr, output logic isStore,
                        output cpuPkg::wordT addr, output cpuPkg::wordT data);
                cpuPkg::opcodeT op;
                cpuPkg::regIdxT ra;
                cpuPkg::regIdxT rb;
                cpuPkg::regIdxT rc;
                cpuPkg::wordT cExt;
                cpuPkg::wordT base;
                op = instr[31:27];
                ra = instr[26:23];
                rb = instr[22:19];
                rc = instr[18:15];
                cExt = {{(`CPU_WORD_WIDTH - `CPU_IMM_WIDTH){instr[`CPU_IMM_WIDTH-1]}},
                        instr[`CPU_IMM_WIDTH-1:0]};
                base = (rb == 4'd0) ? '0 : refRegs[rb];
                isStore = 1'b0;
                addr = base + cExt;
                data = refRegs[ra];
                case (op)
                        cpuPkg::OpLd: refRegs[ra] = mem[addr[MemAddrBits-1:0]];
                        cpuPkg::OpLdi: refRegs[ra] = base + cExt;
                        cpuPkg::OpSt: isStore = 1'b1;
                        cpuPkg::OpAdd: refRegs[ra] = base + refRegs[rc];
                        cpuPkg::OpSub: refRegs[ra] = base - refRegs[rc];
                        cpuPkg::OpAnd: refRegs[ra] = base & refRegs[rc];
                        cpuPkg::OpOr: refRegs[ra] = base | refRegs[rc];
                        default: isStore = 1'b0;
                endcase
        endtask

        // ====================================================================
        // reporting
        // ====================================================================

        task automatic reportMismatch(input string what, input cpuPkg::wordT expected,
                        input cpuPkg::wordT actual);
                $display("ERR %s %s expected %h actual %h", currentTest, what,
                        expected, actual);
                errorCount++;
        endtask

        task automatic reportProblem(input string msg);
                $display("%s: %s", currentTest, msg);
                errorCount++;
        endtask

        task automatic beginTest(input string name);
                currentTest = name;
                testStartErrors = errorCount;
                testCount++;
        endtask

        task automatic endTest();
                $display("%s finished with %0d errors", currentTest,
                        errorCount - testStartErrors);
        endtask

        // ====================================================================
        // instruction runner
        // ====================================================================

        // places one instruction at the expected pc, starts it and follows it to done.
        // busyStart names a cycle in which start is raised again while busy.
        task automatic runInstr(input cpuPkg::wordT instr, input int expLatency,
                        input int busyStart);
                logic expStore;
                logic fetched;
                logic wrote;
                cpuPkg::wordT expAddr;
                cpuPkg::wordT expData;
                cpuPkg::wordT fetchAddr;
                int cycles;
                mem[pcModel[MemAddrBits-1:0]] = instr;
                refExecute(instr, expStore, expAddr, expData);
                fetched = 1'b0;
                wrote = 1'b0;
                fetchAddr = '0;
                cycles = 0;
                @(negedge Clock);
                start = 1'b1;
                while (!done && cycles < 20) begin
                        @(negedge Clock);
                        cycles++;
                        start = (cycles == busyStart);
                        if (memRead && !fetched) begin
                                fetched = 1'b1;
                                fetchAddr = memAddr;
                        end
                        if (memWrite) begin
                                wrote = 1'b1;
                                lastWrAddr = memAddr;
                                lastWrData = memWriteData;
                                mem[memAddr[MemAddrBits-1:0]] = memWriteData;
                        end
                end
                start = 1'b0;
                if (!done) begin
                        reportProblem("done did not arrive within 20 cycles of start");
                end else if (cycles != expLatency) begin
                        reportMismatch("done latency", expLatency, cycles);
                end
                if (!fetched) begin
                        reportProblem("the instruction was never fetched");
                end else if (fetchAddr !== pcModel) begin
                        reportMismatch("fetch address", pcModel, fetchAddr);
                end
                if (expStore && !wrote) begin
                        reportProblem("a store finished without a memory write");
                end else if (expStore) begin
                        if (lastWrAddr !== expAddr) begin
                                reportMismatch("store address", expAddr, lastWrAddr);
                        end
                        if (lastWrData !== expData) begin
                                reportMismatch("store data", expData, lastWrData);
                        end
                end else if (wrote) begin
                        reportProblem(
                                "memory was written by an instruction that is not a store");
                end
                if (busyStart > 0) begin
                        repeat (10) begin
                                @(negedge Clock);
                                if (done) begin
                                        reportProblem(
                                                "a start given while busy produced a second done");
                                end
                        end
                end
                pcModel = pcModel + 32'd1;
        endtask

        // ====================================================================
        // directed tests
        // ====================================================================

        task automatic idleAfterReset();
                beginTest("reset");
                repeat (5) begin
                        @(negedge Clock);
                        if (memRead || memWrite || done) begin
                                reportProblem("memRead, memWrite or done went high before start");
                        end
                end
                runInstr(memInstr(cpuPkg::OpLdi, 4'd1, 4'd0, 5), 7, 0);
                endTest();
        endtask

        task automatic loadImmThenStore();
                beginTest("ldi and st");
                runInstr(memInstr(cpuPkg::OpLdi, 4'd2, 4'd0, -1234), 7, 0);
                runInstr(memInstr(cpuPkg::OpSt, 4'd2, 4'd0, 200), 9, 0);
                if (lastWrAddr !== 32'd200) begin
                        reportMismatch("st address", 32'd200, lastWrAddr);
                end
                if (lastWrData !== 32'hfffffb2e) begin
                        reportMismatch("sign extended C", 32'hfffffb2e, lastWrData);
                end
                endTest();
        endtask

        task automatic aluOperations();
                cpuPkg::wordT a;
                cpuPkg::wordT b;
                cpuPkg::wordT expected;
                cpuPkg::opcodeT ops [4];
                int k;
                beginTest("alu ops");
                a = $random(seed);
                b = $random(seed);
                mem[160] = a;
                mem[161] = b;
                ops = '{cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpAnd, cpuPkg::OpOr};
                runInstr(memInstr(cpuPkg::OpLd, 4'd3, 4'd0, 160), 9, 0);
                runInstr(memInstr(cpuPkg::OpLd, 4'd4, 4'd0, 161), 9, 0);
                for (k = 0; k < 4; k++) begin
                        case (k)
                                0: expected = a + b;
                                1: expected = a - b;
                                2: expected = a & b;
                                default: expected = a | b;
                        endcase
                        runInstr(aluInstr(ops[k], 4'd5, 4'd3, 4'd4), 7, 0);
                        runInstr(memInstr(cpuPkg::OpSt, 4'd5, 4'd0, 170 + k), 9, 0);
                        if (lastWrData !== expected) begin
                                reportMismatch("alu result", expected, lastWrData);
                        end
                end
                endTest();
        endtask

        task automatic baseRegisterAddressing();
                cpuPkg::wordT word;
                beginTest("base address");
                word = $random(seed);
                mem[185] = word;
                runInstr(memInstr(cpuPkg::OpLdi, 4'd6, 4'd0, 180), 7, 0);
                runInstr(memInstr(cpuPkg::OpLd, 4'd7, 4'd6, 5), 9, 0);
                runInstr(memInstr(cpuPkg::OpSt, 4'd7, 4'd6, 15), 9, 0);
                if (lastWrAddr !== 32'd195) begin
                        reportMismatch("Rb plus C address", 32'd195, lastWrAddr);
                end
                if (lastWrData !== word) begin
                        reportMismatch("loaded word", word, lastWrData);
                end
                endTest();
        endtask

        task automatic latencyAndBusyStart();
                beginTest("latency");
                runInstr(memInstr(cpuPkg::OpLdi, 4'd8, 4'd0, 7), 7, 0);
                runInstr(aluInstr(cpuPkg::OpAdd, 4'd9, 4'd8, 4'd8), 7, 0);
                runInstr(memInstr(cpuPkg::OpLd, 4'd10, 4'd0, 160), 9, 0);
                runInstr(memInstr(cpuPkg::OpSt, 4'd10, 4'd0, 210), 9, 0);
                // the next fetch address shows whether the busy start moved the pc.
                runInstr(memInstr(cpuPkg::OpLdi, 4'd11, 4'd0, 3), 7, 3);
                runInstr(aluInstr(cpuPkg::OpOr, 4'd12, 4'd8, 4'd8), 7, 0);
                endTest();
        endtask

        task automatic unknownOpcodes();
                beginTest("no-op");
                runInstr(memInstr(cpuPkg::OpLdi, 4'd13, 4'd0, 32'h1234), 7, 0);
                runInstr(aluInstr(5'd9, 4'd13, 4'd8, 4'd8), 7, 0);
                runInstr(memInstr(5'd31, 4'd13, 4'd0, -1), 7, 0);
                runInstr(memInstr(cpuPkg::OpSt, 4'd13, 4'd0, 220), 9, 0);
                if (lastWrData !== 32'h1234) begin
                        reportMismatch("register after no-op", 32'h1234, lastWrData);
                end
                endTest();
        endtask

        // ====================================================================
        // main sequence and watchdog
        // ====================================================================

        initial begin
                start = 1'b0;
                seed = 32'hff40a58d;
                errorCount = 0;
                testCount = 0;
                testStartErrors = 0;
                pcModel = '0;
                lastWrAddr = '0;
                lastWrData = '0;
                for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                        refRegs[i] = '0;
                end
                for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
                        mem[i] = 32'h9e3779b9 * (i + 1);
                end
                wait (arstN === 1'b1);
                idleAfterReset();
                loadImmThenStore();
                aluOperations();
                baseRegisterAddressing();
                latencyAndBusyStart();
                unknownOpcodes();
                $display("%0d tests run, %0d errors", testCount, errorCount);
                if (errorCount == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

        initial begin
                repeat (WatchdogCycles) @(posedge Clock);
                $display("watchdog expired after %0d cycles before the tests finished",
                        WatchdogCycles);
                $display("Errors found");
                $finish;
        end

endmodule

/* testbench/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
        output logic Clock,
        output logic arstN
);

        // the clock period is 4 ns.
        initial begin
                Clock = 1'b0;
                forever begin
                        #2 Clock = ~Clock;
                end
        end

        // reset stays low for five rising edges and lifts between edges.
        initial begin
                arstN = 1'b0;
                repeat (5) @(posedge Clock);
                @(negedge Clock);
                arstN = 1'b1;
        end

endmodule

/* src/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
        input  logic         Clock,
        input  logic         arstN,
        input  logic         start,
        input  cpuPkg::wordT memReadData,
        output cpuPkg::wordT memAddr,
        output cpuPkg::wordT memWriteData,
        output logic         memRead,
        output logic         memWrite,
        output logic         done
);

        cpuPkg::ctrlT ctrl;
        cpuPkg::instrFieldsT fields;
        cpuPkg::regIdxT regIdx;
        cpuPkg::wordT bus;
        cpuPkg::wordT regData;
        cpuPkg::wordT pc;
        cpuPkg::wordT z;
        logic regWrite;
        logic baZero;

        controlSequencer u_sequencer (
                .Clock(Clock),
                .arstN(arstN),
                .start(start),
                .opcode(fields.opcode),
                .ctrl(ctrl),
                .memRead(memRead),
                .memWrite(memWrite),
                .done(done)
        );

        instrDecode u_decode (
                .Clock(Clock),
                .arstN(arstN),
                .ctrl(ctrl),
                .bus(bus),
                .fields(fields),
                .regIdx(regIdx),
                .regWrite(regWrite),
                .baZero(baZero)
        );

        registerFile u_regs (
                .Clock(Clock),
                .arstN(arstN),
                .regIdx(regIdx),
                .regWrite(regWrite),
                .writeData(bus),
                .baZero(baZero),
                .readData(regData)
        );

        aluExecute u_execute (
                .Clock(Clock),
                .arstN(arstN),
                .ctrl(ctrl),
                .opcode(fields.opcode),
                .cExt(fields.cExt),
                .bus(bus),
                .pc(pc),
                .z(z)
        );

        busResult u_result (
                .Clock(Clock),
                .arstN(arstN),
                .ctrl(ctrl),
                .pc(pc),
                .regData(regData),
                .z(z),
                .memReadData(memReadData),
                .bus(bus),
                .memAddr(memAddr),
                .memWriteData(memWriteData)
        );

endmodule

/* src/busResult.sv */
`timescale 1ns/1ps

module busResult (
        input  logic         Clock,
        input  logic         arstN,
        input  cpuPkg::ctrlT ctrl,
        input  cpuPkg::wordT pc,
        input  cpuPkg::wordT regData,
        input  cpuPkg::wordT z,
        input  cpuPkg::wordT memReadData,
        output cpuPkg::wordT bus,
        output cpuPkg::wordT memAddr,
        output cpuPkg::wordT memWriteData
);

        cpuPkg::wordT mdrReg;
        cpuPkg::wordT marReg;

        // ====================================================================
        // bus source select
        // ====================================================================

        always_comb begin
                case (ctrl.busSrc)
                        cpuPkg::BusPc: bus = pc;
                        cpuPkg::BusReg: bus = regData;
                        cpuPkg::BusZ: bus = z;
                        default: bus = mdrReg;
                endcase
        end

        // ====================================================================
        // memory interface registers
        // ====================================================================

        // the memory data register takes the bus only for the store path.
        always_ff @(posedge Clock) begin
                if (ctrl.mdrIn) begin
                        mdrReg <= ctrl.mdrFromBus ? bus : memReadData;
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        marReg <= '0;
                end else if (ctrl.marIn) begin
                        marReg <= bus;
                end
        end

        assign memAddr = marReg;
        assign memWriteData = mdrReg;

        // the fetch cycle must actually route the program counter onto the bus.
        pcOnBus: assert property (@(posedge Clock) disable iff (!arstN)
                ctrl.pcOut |-> (ctrl.busSrc == cpuPkg::BusPc));

endmodule

/* src/aluExecute.sv */
`timescale 1ns/1ps

module aluExecute (
        input  logic           Clock,
        input  logic           arstN,
        input  cpuPkg::ctrlT   ctrl,
        input  cpuPkg::opcodeT opcode,
        input  cpuPkg::wordT   cExt,
        input  cpuPkg::wordT   bus,
        output cpuPkg::wordT   pc,
        output cpuPkg::wordT   z
);

        cpuPkg::wordT yReg;
        cpuPkg::wordT zReg;
        cpuPkg::wordT operandB;
        cpuPkg::wordT aluResult;

        // ====================================================================
        // operand and result registers
        // ====================================================================

        always_ff @(posedge Clock) begin
                if (ctrl.yIn) begin
                        yReg <= bus;
                end
                if (ctrl.zIn) begin
                        zReg <= aluResult;
                end
        end

        assign z = zReg;

        // ====================================================================
        // ALU
        // ====================================================================

        assign operandB = ctrl.cOut ? cExt : bus;

        // address arithmetic for ld, ldi and st shares the adder with add.
        always_comb begin
                case (opcode)
                        cpuPkg::OpSub: aluResult = yReg - operandB;
                        cpuPkg::OpAnd: aluResult = yReg & operandB;
                        cpuPkg::OpOr: aluResult = yReg | operandB;
                        default: aluResult = yReg + operandB;
                endcase
        end

        // ====================================================================
        // program counter
        // ====================================================================

        // memory is word addressed, so the next instruction is one step on.
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        pc <= '0;
                end else if (ctrl.incPc) begin
                        pc <= pc + 1'b1;
                end
        end

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

`include "cpu_settings.svh"

module registerFile (
        input  logic           Clock,
        input  logic           arstN,
        input  cpuPkg::regIdxT regIdx,
        input  logic           regWrite,
        input  cpuPkg::wordT   writeData,
        input  logic           baZero,
        output cpuPkg::wordT   readData
);

        cpuPkg::wordT regs [`CPU_NUM_REGS];

        // one index serves both ports, so a write and a read never name
        // different registers in the same cycle.
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (regWrite) begin
                        regs[regIdx] <= writeData;
                end
        end

        assign readData = baZero ? '0 : regs[regIdx];

endmodule

/* src/instrDecode.sv */
`timescale 1ns/1ps

`include "cpu_settings.svh"

module instrDecode (
        input  logic                Clock,
        input  logic                arstN,
        input  cpuPkg::ctrlT        ctrl,
        input  cpuPkg::wordT        bus,
        output cpuPkg::instrFieldsT fields,
        output cpuPkg::regIdxT      regIdx,
        output logic                regWrite,
        output logic                baZero
);

        cpuPkg::wordT irReg;
        logic knownOp;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        irReg <= '0;
                end else if (ctrl.irIn) begin
                        irReg <= bus;
                end
        end

        // ====================================================================
        // field extraction
        // ====================================================================

        assign fields.opcode = irReg[31:27];
        assign fields.ra = irReg[26:23];
        assign fields.rb = irReg[22:19];
        assign fields.rc = irReg[18:15];

        // C overlaps the Rc field and is sign extended from its top bit.
        assign fields.cExt = {{(`CPU_WORD_WIDTH - `CPU_IMM_WIDTH){irReg[`CPU_IMM_WIDTH-1]}},
                irReg[`CPU_IMM_WIDTH-1:0]};

        // ====================================================================
        // register select
        // ====================================================================

        always_comb begin
                if (ctrl.gra) begin
                        regIdx = fields.ra;
                end else if (ctrl.grb) begin
                        regIdx = fields.rb;
                end else if (ctrl.grc) begin
                        regIdx = fields.rc;
                end else begin
                        regIdx = '0;
                end
        end

        // opcodes above or are no-ops and must leave the registers alone.
        assign knownOp = (fields.opcode <= cpuPkg::OpOr);
        assign regWrite = ctrl.rIn && knownOp;

        // base addressing reads R0 as the constant zero.
        assign baZero = ctrl.grb && (fields.rb == '0);

        oneSelect: assert property (@(posedge Clock) disable iff (!arstN)
                $onehot0({ctrl.gra, ctrl.grb, ctrl.grc}));

endmodule

/* src/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer (
        input  logic           Clock,
        input  logic           arstN,
        input  logic           start,
        input  cpuPkg::opcodeT opcode,
        output cpuPkg::ctrlT   ctrl,
        output logic           memRead,
        output logic           memWrite,
        output logic           done
);

        cpuPkg::stateT state;
        cpuPkg::stateT nextState;
        logic isLd;
        logic isSt;
        logic usesConst;

        assign isLd = (opcode == cpuPkg::OpLd);
        assign isSt = (opcode == cpuPkg::OpSt);
        assign usesConst = isLd || isSt || (opcode == cpuPkg::OpLdi);

        // ====================================================================
        // state register
        // ====================================================================

        always_comb begin
                case (state)
                        cpuPkg::Idle: nextState = start ? cpuPkg::T0 : cpuPkg::Idle;
                        cpuPkg::T0: nextState = cpuPkg::T1;
                        cpuPkg::T1: nextState = cpuPkg::T2;
                        cpuPkg::T2: nextState = cpuPkg::T3;
                        cpuPkg::T3: nextState = cpuPkg::T4;
                        cpuPkg::T4: nextState = cpuPkg::T5;
                        cpuPkg::T5: nextState = (isLd || isSt) ? cpuPkg::T6 : cpuPkg::Idle;
                        cpuPkg::T6: nextState = cpuPkg::T7;
                        default: nextState = cpuPkg::Idle;
                endcase
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        state <= cpuPkg::Idle;
                        done <= 1'b0;
                end else begin
                        state <= nextState;
                        // done follows the last state of either sequence length.
                        done <= (state == cpuPkg::T7) ||
                                ((state == cpuPkg::T5) && !(isLd || isSt));
                end
        end

        // ====================================================================
        // control decode
        // ====================================================================

        always_comb begin
                ctrl = '0;
                memRead = 1'b0;
                memWrite = 1'b0;
                case (state)
                        cpuPkg::T0: begin
                                ctrl.pcOut = 1'b1;
                                ctrl.busSrc = cpuPkg::BusPc;
                                ctrl.marIn = 1'b1;
                                ctrl.incPc = 1'b1;
                        end
                        cpuPkg::T1: begin
                                memRead = 1'b1;
                                ctrl.mdrIn = 1'b1;
                        end
                        cpuPkg::T2: begin
                                ctrl.busSrc = cpuPkg::BusMdr;
                                ctrl.irIn = 1'b1;
                        end
                        cpuPkg::T3: begin
                                ctrl.grb = 1'b1;
                                ctrl.busSrc = cpuPkg::BusReg;
                                ctrl.yIn = 1'b1;
                        end
                        cpuPkg::T4: begin
                                ctrl.cOut = usesConst;
                                ctrl.grc = !usesConst;
                                ctrl.busSrc = cpuPkg::BusReg;
                                ctrl.zIn = 1'b1;
                        end
                        cpuPkg::T5: begin
                                ctrl.busSrc = cpuPkg::BusZ;
                                ctrl.marIn = isLd || isSt;
                                ctrl.gra = !(isLd || isSt);
                                ctrl.rIn = !(isLd || isSt);
                        end
                        cpuPkg::T6: begin
                                memRead = isLd;
                                ctrl.mdrIn = 1'b1;
                                ctrl.mdrFromBus = isSt;
                                ctrl.gra = isSt;
                                ctrl.busSrc = cpuPkg::BusReg;
                        end
                        cpuPkg::T7: begin
                                memWrite = isSt;
                                ctrl.gra = isLd;
                                ctrl.rIn = isLd;
                                ctrl.busSrc = cpuPkg::BusMdr;
                        end
                        default: begin
                                ctrl = '0;
                        end
                endcase
        end

        memExclusive: assert property (@(posedge Clock) disable iff (!arstN)
                !(memRead && memWrite));

        donePulse: assert property (@(posedge Clock) disable iff (!arstN)
                done |=> !done);

endmodule

/* src/cpuPkg.sv */
`include "cpu_settings.svh"

package cpuPkg;

        // ====================================================================
        // vector types
        // ====================================================================

        typedef logic [`CPU_WORD_WIDTH-1:0] wordT;
        typedef logic [`CPU_REG_IDX_WIDTH-1:0] regIdxT;
        typedef logic [`CPU_OPCODE_WIDTH-1:0] opcodeT;

        // bus source select, 0 pc, 1 register file, 2 Z, 3 memory data register.
        typedef logic [1:0] busSrcT;

        localparam busSrcT BusPc = 2'd0;
        localparam busSrcT BusReg = 2'd1;
        localparam busSrcT BusZ = 2'd2;
        localparam busSrcT BusMdr = 2'd3;

        // supported opcodes; anything above OpOr runs as a no-op.
        localparam opcodeT OpLd = 5'd0;
        localparam opcodeT OpLdi = 5'd1;
        localparam opcodeT OpSt = 5'd2;
        localparam opcodeT OpAdd = 5'd3;
        localparam opcodeT OpSub = 5'd4;
        localparam opcodeT OpAnd = 5'd5;
        localparam opcodeT OpOr = 5'd6;

        typedef enum logic [3:0] {
                Idle,
                T0,
                T1,
                T2,
                T3,
                T4,
                T5,
                T6,
                T7
        } stateT;

        // ====================================================================
        // structs
        // ====================================================================

        // control strobes for one cycle of the instruction sequence.
        typedef struct packed {
                logic pcOut;
                logic incPc;
                logic marIn;
                logic mdrIn;
                logic mdrFromBus;
                logic irIn;
                logic yIn;
                logic zIn;
                logic cOut;
                logic gra;
                logic grb;
                logic grc;
                logic rIn;
                busSrcT busSrc;
        } ctrlT;

        typedef struct packed {
                opcodeT opcode;
                regIdxT ra;
                regIdxT rb;
                regIdxT rc;
                wordT cExt;
        } instrFieldsT;

endpackage

/* src/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ============================================================================
// core dimensions
// ============================================================================

// data, address and instruction words are all one width.
`define CPU_WORD_WIDTH 32

// general purpose register count and the width of a register number.
`define CPU_NUM_REGS 16
`define CPU_REG_IDX_WIDTH 4

// opcode field in the top bits of the instruction word.
`define CPU_OPCODE_WIDTH 5

// signed constant C in the low bits of the instruction word.
`define CPU_IMM_WIDTH 19

// word-addressed memory depth seen by the core.
`define CPU_MEM_WORDS 256

`endif
